//--- Makefile
OBJ_DIR := obj_dir

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level on its own
lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module concat_top

# Build and run the testbench, a $fatal gives a nonzero exit status
sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module concat_tb -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vconcat_tb

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
design/concat_fmt_pkg.sv
design/concat_stat_pkg.sv
design/concat_stream_if.sv
design/concat_skid.sv
design/concat_packer.sv
design/concat_stats.sv
design/concat_top.sv
dv/concat_tb.sv

//--- design/concat_fmt_pkg.sv
package concat_fmt_pkg;

    // Bits in one byte lane
    localparam int BYTE_W = 8;

    // Byte lanes in one input beat
    localparam int IN_BYTES = 2;

    // Input beat data width
    localparam int IN_W = IN_BYTES * BYTE_W;

    // Width of the input byte count, wide enough to hold IN_BYTES
    localparam int IN_CNT_W = $clog2(IN_BYTES + 1);

    // Valid bytes in an input beat, 1 or 2
    typedef logic [IN_CNT_W-1:0] in_count_t;

    // Output word size in bytes unless the top level overrides it
    localparam int OUT_BYTES_DEFAULT = 8;

endpackage : concat_fmt_pkg

//--- design/concat_packer.sv
`timescale 1ns/1ps

module concat_packer #(
    parameter int OUT_BYTES = concat_fmt_pkg::OUT_BYTES_DEFAULT
) (
    input  logic            i_clock,
    input  logic            i_reset,
    concat_stream_if.sink   s,
    concat_stream_if.source m
);

    localparam int BYTE_W = concat_fmt_pkg::BYTE_W;
    localparam int OUT_W  = OUT_BYTES * BYTE_W;
    localparam int CNT_W  = $clog2(OUT_BYTES + 1);
    // One extra bit so fill plus beat never overflows
    localparam int SUM_W  = CNT_W + 1;

    logic [OUT_W-1:0]  acc_q;
    logic [OUT_W-1:0]  merged;
    logic [OUT_W-1:0]  out_data_q;
    logic [CNT_W-1:0]  fill_q;
    logic [CNT_W-1:0]  out_bytes_q;
    logic [BYTE_W-1:0] spill_q;
    logic [BYTE_W-1:0] byte_lo;
    logic [BYTE_W-1:0] byte_hi;
    logic [SUM_W-1:0]  fill_sum;

    concat_fmt_pkg::in_count_t beat_cnt;

    logic spill_last_q;
    logic out_last_q;
    logic out_valid_q;
    logic out_free;
    logic in_fire;
    logic out_fire;
    logic word_full;
    logic word_spill;
    logic emit;
    logic flush_spill;

    assign beat_cnt = s.bytes;
    assign byte_lo  = s.data[BYTE_W-1:0];
    assign byte_hi  = s.data[concat_fmt_pkg::IN_W-1 -: BYTE_W];

    // Output register is free when empty or drained this cycle
    assign out_fire    = out_valid_q && m.ready;
    assign out_free    = !out_valid_q || m.ready;
    assign flush_spill = spill_last_q && out_free;

    // Input stalls for the lone spill word
    assign s.ready  = out_free && !spill_last_q;
    assign in_fire  = s.valid && s.ready;

    assign fill_sum   = SUM_W'(fill_q) + SUM_W'(beat_cnt);
    assign word_full  = fill_sum >= SUM_W'(OUT_BYTES);
    assign word_spill = fill_sum > SUM_W'(OUT_BYTES);
    assign emit       = in_fire && (word_full || s.last);

    assign m.data  = out_data_q;
    assign m.bytes = out_bytes_q;
    assign m.last  = out_last_q;
    assign m.valid = out_valid_q;

    // Old bytes below the fill point, new bytes on top, zeros above
    always_comb begin
        for (int i = 0; i < OUT_BYTES; i++) begin
            if (i < int'(fill_q)) begin
                merged[i*BYTE_W +: BYTE_W] = acc_q[i*BYTE_W +: BYTE_W];
            end else if (i == int'(fill_q)) begin
                merged[i*BYTE_W +: BYTE_W] = byte_lo;
            end else if (beat_cnt == concat_fmt_pkg::IN_BYTES && i == int'(fill_q) + 1) begin
                merged[i*BYTE_W +: BYTE_W] = byte_hi;
            end else begin
                merged[i*BYTE_W +: BYTE_W] = '0;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            fill_q       <= '0;
            spill_last_q <= 1'b0;
            out_valid_q  <= 1'b0;
        end else begin
            if (out_fire) begin
                out_valid_q <= 1'b0;
            end
            if (flush_spill) begin
                out_valid_q  <= 1'b1;
                spill_last_q <= 1'b0;
            end else if (in_fire) begin
                if (emit) begin
                    out_valid_q <= 1'b1;
                end
                if (word_spill) begin
                    // High byte opens the next word or goes out alone
                    fill_q       <= s.last ? '0 : CNT_W'(1);
                    spill_last_q <= s.last;
                end else if (emit) begin
                    fill_q <= '0;
                end else begin
                    fill_q <= fill_sum[CNT_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (flush_spill) begin
            out_data_q  <= OUT_W'(spill_q);
            out_bytes_q <= CNT_W'(1);
            out_last_q  <= 1'b1;
        end else if (emit) begin
            out_data_q  <= merged;
            out_bytes_q <= word_full ? CNT_W'(OUT_BYTES) : fill_sum[CNT_W-1:0];
            out_last_q  <= s.last && !word_spill;
        end
        if (in_fire && word_spill) begin
            spill_q <= byte_hi;
            acc_q   <= OUT_W'(byte_hi);
        end else if (in_fire && !emit) begin
            acc_q <= merged;
        end
    end

    // Upstream only ever hands over one or two bytes
    a_in_count: assert property (
        @(posedge i_clock) disable iff (i_reset)
        (s.valid && s.ready) |-> (s.bytes inside {2'd1, 2'd2})
    );

    // Every emitted word carries at least one byte
    a_out_count: assert property (
        @(posedge i_clock) disable iff (i_reset)
        m.valid |-> (m.bytes != '0)
    );

endmodule : concat_packer

//--- design/concat_skid.sv
`timescale 1ns/1ps

module concat_skid #(
    parameter int WIDTH = 19
) (
    input  logic            i_clock,
    input  logic            i_reset,
    concat_stream_if.sink   s,
    concat_stream_if.source m
);

    // Bit 0 of the state doubles as the output valid flag
    typedef enum logic [1:0] {
        ST_EMPTY = 2'b00,
        ST_ONE   = 2'b01,
        ST_TWO   = 2'b11
    } state_t;

    state_t state_q;
    state_t state_d;

    logic [WIDTH-1:0] in_word;
    logic [WIDTH-1:0] out_q;
    logic [WIDTH-1:0] skid_q;

    logic ready_q;
    logic in_fire;
    logic out_fire;
    logic load_in;
    logic load_skid;
    logic load_from_skid;

    // Flatten the stream fields into one stored word
    assign in_word = {s.data, s.bytes, s.last};

    assign s.ready  = ready_q;
    assign m.valid  = state_q[0];
    assign {m.data, m.bytes, m.last} = out_q;

    assign in_fire  = s.valid && ready_q;
    assign out_fire = state_q[0] && m.ready;

    always_comb begin
        state_d        = state_q;
        load_in        = 1'b0;
        load_skid      = 1'b0;
        load_from_skid = 1'b0;
        case (state_q)
            ST_EMPTY: begin
                if (in_fire) begin
                    load_in = 1'b1;
                    state_d = ST_ONE;
                end
            end
            ST_ONE: begin
                case ({in_fire, out_fire})
                    2'b11: begin
                        load_in = 1'b1;
                    end
                    2'b10: begin
                        // Ready was still high, catch the late beat
                        load_skid = 1'b1;
                        state_d   = ST_TWO;
                    end
                    2'b01: begin
                        state_d = ST_EMPTY;
                    end
                    default: begin
                    end
                endcase
            end
            ST_TWO: begin
                // Input is held off here, only drain
                if (out_fire) begin
                    load_from_skid = 1'b1;
                    state_d        = ST_ONE;
                end
            end
            default: begin
                state_d = ST_EMPTY;
            end
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state_q <= ST_EMPTY;
            ready_q <= 1'b0;
        end else begin
            state_q <= state_d;
            ready_q <= (state_d != ST_TWO);
        end
    end

    always_ff @(posedge i_clock) begin
        if (load_in) begin
            out_q <= in_word;
        end else if (load_from_skid) begin
            out_q <= skid_q;
        end
        if (load_skid) begin
            skid_q <= in_word;
        end
    end

    // A stalled output word must not move or vanish
    a_hold_stable: assert property (
        @(posedge i_clock) disable iff (i_reset)
        (m.valid && !m.ready) |=> (m.valid && $stable(out_q))
    );

endmodule : concat_skid

//--- design/concat_stat_pkg.sv
package concat_stat_pkg;

    // Width of every statistics counter
    localparam int STAT_W = 16;

    // Free-running counter value, wraps at 2**STAT_W
    typedef logic [STAT_W-1:0] stat_count_t;

endpackage : concat_stat_pkg

//--- design/concat_stats.sv
`timescale 1ns/1ps

module concat_stats (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_valid,
    input  logic                        i_ready,
    input  logic                        i_last,
    output concat_stat_pkg::stat_count_t o_word_count,
    output concat_stat_pkg::stat_count_t o_packet_count
);

    concat_stat_pkg::stat_count_t word_q;
    concat_stat_pkg::stat_count_t packet_q;

    logic xfer;

    // Count only completed handshakes on the output stream
    assign xfer = i_valid && i_ready;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            word_q   <= '0;
            packet_q <= '0;
        end else begin
            if (xfer) begin
                word_q <= word_q + 1'b1;
            end
            // The word with last closes a packet
            if (xfer && i_last) begin
                packet_q <= packet_q + 1'b1;
            end
        end
    end

    assign o_word_count   = word_q;
    assign o_packet_count = packet_q;

endmodule : concat_stats

//--- design/concat_stream_if.sv
`timescale 1ns/1ps

// One ready/valid stream
// A beat moves on a rising edge with valid and ready both high
interface concat_stream_if #(
    parameter int DATA_W = concat_fmt_pkg::IN_W,
    parameter int CNT_W  = concat_fmt_pkg::IN_CNT_W
);

    logic [DATA_W-1:0] data;
    logic [CNT_W-1:0]  bytes;
    logic              last;
    logic              valid;
    logic              ready;

    // Producer side
    modport source (
        output data,
        output bytes,
        output last,
        output valid,
        input  ready
    );

    // Consumer side
    modport sink (
        input  data,
        input  bytes,
        input  last,
        input  valid,
        output ready
    );

endinterface : concat_stream_if

//--- design/concat_top.sv
`timescale 1ns/1ps

module concat_top #(
    parameter int OUT_BYTES = concat_fmt_pkg::OUT_BYTES_DEFAULT,
    localparam int OUT_CNT_W = $clog2(OUT_BYTES + 1)
) (
    input  logic                                       i_clock,
    input  logic                                       i_reset,
    input  logic [concat_fmt_pkg::IN_W-1:0]            i_in_data,
    input  concat_fmt_pkg::in_count_t                  i_in_bytes,
    input  logic                                       i_in_last,
    input  logic                                       i_in_valid,
    output logic                                       o_in_ready,
    output logic [OUT_BYTES*concat_fmt_pkg::BYTE_W-1:0] o_out_data,
    output logic [OUT_CNT_W-1:0]                       o_out_bytes,
    output logic                                       o_out_last,
    output logic                                       o_out_valid,
    input  logic                                       i_out_ready,
    output concat_stat_pkg::stat_count_t               o_word_count,
    output concat_stat_pkg::stat_count_t               o_packet_count
);

    localparam int IN_W       = concat_fmt_pkg::IN_W;
    localparam int IN_CNT_W   = concat_fmt_pkg::IN_CNT_W;
    localparam int OUT_W      = OUT_BYTES * concat_fmt_pkg::BYTE_W;
    // Data, byte count and last packed side by side
    localparam int IN_SKID_W  = IN_W + IN_CNT_W + 1;
    localparam int OUT_SKID_W = OUT_W + OUT_CNT_W + 1;

    concat_stream_if #(.DATA_W(IN_W), .CNT_W(IN_CNT_W)) in_port_if ();
    concat_stream_if #(.DATA_W(IN_W), .CNT_W(IN_CNT_W)) beat_if ();
    concat_stream_if #(.DATA_W(OUT_W), .CNT_W(OUT_CNT_W)) word_if ();
    concat_stream_if #(.DATA_W(OUT_W), .CNT_W(OUT_CNT_W)) out_port_if ();

    // Input pins onto the input skid
    assign in_port_if.data  = i_in_data;
    assign in_port_if.bytes = i_in_bytes;
    assign in_port_if.last  = i_in_last;
    assign in_port_if.valid = i_in_valid;
    assign o_in_ready       = in_port_if.ready;

    // Output skid onto the output pins
    assign o_out_data        = out_port_if.data;
    assign o_out_bytes       = out_port_if.bytes;
    assign o_out_last        = out_port_if.last;
    assign o_out_valid       = out_port_if.valid;
    assign out_port_if.ready = i_out_ready;

    concat_skid #(.WIDTH(IN_SKID_W)) u_skid_in (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .s       (in_port_if.sink),
        .m       (beat_if.source)
    );

    concat_packer #(.OUT_BYTES(OUT_BYTES)) u_packer (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .s       (beat_if.sink),
        .m       (word_if.source)
    );

    concat_skid #(.WIDTH(OUT_SKID_W)) u_skid_out (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .s       (word_if.sink),
        .m       (out_port_if.source)
    );

    concat_stats u_stats (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (o_out_valid),
        .i_ready        (i_out_ready),
        .i_last         (o_out_last),
        .o_word_count   (o_word_count),
        .o_packet_count (o_packet_count)
    );

endmodule : concat_top

//--- dv/concat_tb.sv
`timescale 1ns/1ps

module concat_tb;

    localparam int OUT_BYTES = 8;
    localparam int OUT_CNT_W = $clog2(OUT_BYTES + 1);
    localparam int NUM_RESET = 10;
    localparam int TIMEOUT = 1000;
    localparam logic [31:0] SEED = 32'd36;

    // Beat split patterns
    localparam int SPLIT_TWO = 0;
    localparam int SPLIT_ONE = 1;
    localparam int SPLIT_LEAD1 = 2;
    localparam int SPLIT_RUN7 = 3;

    // Each case gives packet length in bytes, split pattern and percent of cycles with ready low
    localparam int NUM_CASES = 12;
    localparam int CASE_LEN [NUM_CASES] = '{16, 1, 3, 5, 9, 12, 20, 40, 23, 17, 9, 33};
    localparam int CASE_SPLIT [NUM_CASES] = '{
        SPLIT_TWO, SPLIT_ONE, SPLIT_TWO, SPLIT_LEAD1, SPLIT_LEAD1, SPLIT_RUN7,
        SPLIT_ONE, SPLIT_TWO, SPLIT_LEAD1, SPLIT_RUN7, SPLIT_LEAD1, SPLIT_ONE
    };
    localparam int CASE_THROTTLE [NUM_CASES] = '{0, 0, 0, 0, 0, 0, 0, 50, 40, 70, 60, 30};

    logic i_clock;
    logic i_reset;
    logic [15:0] i_in_data;
    concat_fmt_pkg::in_count_t i_in_bytes;
    logic i_in_last;
    logic i_in_valid;
    logic o_in_ready;
    logic [OUT_BYTES*8-1:0] o_out_data;
    logic [OUT_CNT_W-1:0] o_out_bytes;
    logic o_out_last;
    logic o_out_valid;
    logic i_out_ready;
    concat_stat_pkg::stat_count_t o_word_count;
    concat_stat_pkg::stat_count_t o_packet_count;

    // Reference model state
    logic [7:0] pkt_bytes [$];
    logic [63:0] exp_data [$];
    int exp_bytes [$];
    logic exp_last [$];
    int words_expected;
    int packets_sent;
    int throttle_pct;
    logic [31:0] data_rng;
    logic [31:0] ready_rng;

    concat_top #(.OUT_BYTES(OUT_BYTES)) uut (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_in_data      (i_in_data),
        .i_in_bytes     (i_in_bytes),
        .i_in_last      (i_in_last),
        .i_in_valid     (i_in_valid),
        .o_in_ready     (o_in_ready),
        .o_out_data     (o_out_data),
        .o_out_bytes    (o_out_bytes),
        .o_out_last     (o_out_last),
        .o_out_valid    (o_out_valid),
        .i_out_ready    (i_out_ready),
        .o_word_count   (o_word_count),
        .o_packet_count (o_packet_count)
    );

    initial begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int beat_size(input int split, input int beat, input int rem);
        int want;
        case (split)
            SPLIT_ONE: want = 1;
            SPLIT_LEAD1: want = (beat == 0) ? 1 : 2;
            SPLIT_RUN7: want = (beat < 7) ? 1 : 2;
            default: want = 2;
        endcase
        return (want > rem) ? rem : want;
    endfunction

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s, got %0h expected %0h", $time, what, got, expected);
            stop_with_failure();
        end
    endtask

    // Dense packing, low byte first, last word takes the remainder
    task automatic add_expected(input int len);
        logic [63:0] word;
        int fill;
        word = '0;
        fill = 0;
        for (int i = 0; i < len; i++) begin
            word[fill*8 +: 8] = pkt_bytes[i];
            fill = fill + 1;
            if (fill == OUT_BYTES || i == len - 1) begin
                exp_data.push_back(word);
                exp_bytes.push_back(fill);
                exp_last.push_back(i == len - 1);
                words_expected = words_expected + 1;
                word = '0;
                fill = 0;
            end
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic send_beat(input logic [15:0] data, input int cnt, input logic last);
        int waited;
        waited = 0;
        i_in_data = data;
        i_in_bytes = concat_fmt_pkg::in_count_t'(cnt);
        i_in_last = last;
        i_in_valid = 1'b1;
        @(negedge i_clock);
        while (!o_in_ready) begin
            waited = waited + 1;
            if (waited > TIMEOUT) begin
                $display("Input handshake stalled, o_in_ready stayed low for a beat");
                stop_with_failure();
            end
            @(negedge i_clock);
        end
        @(posedge i_clock);
        #1;
        i_in_valid = 1'b0;
        i_in_last = 1'b0;
    endtask

    // Returns on the edge that takes the last expected word
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data.size() != 0) begin
            waited = waited + 1;
            if (waited > TIMEOUT) begin
                $display("Output handshake stalled, expected words never left the DUT");
                stop_with_failure();
            end
            @(posedge i_clock);
        end
    endtask

    // Random back-pressure on the output
    initial begin
        i_out_ready = 1'b0;
        ready_rng = next_rand(SEED);
        forever begin
            @(posedge i_clock);
            #1;
            ready_rng = next_rand(ready_rng);
            i_out_ready = (int'(ready_rng % 100) >= throttle_pct);
        end
    end

    // Checks each output transfer in the middle of the cycle
    initial begin : monitor
        logic held;
        logic [63:0] held_data;
        logic [63:0] want_data;
        int want_bytes;
        logic want_last;
        held = 1'b0;
        held_data = '0;
        forever begin
            @(negedge i_clock);
            if (held) begin
                check_value("o_out_valid dropped under back-pressure", 64'(o_out_valid), 64'd1);
                check_value("o_out_data moved under back-pressure", 64'(o_out_data), held_data);
            end
            held = o_out_valid && !i_out_ready && !i_reset;
            held_data = 64'(o_out_data);
            if (o_out_valid && i_out_ready && !i_reset) begin
                if (exp_data.size() == 0) begin
                    $display("Unexpected output word, the reference model had none left");
                    stop_with_failure();
                end
                want_data = exp_data.pop_front();
                want_bytes = exp_bytes.pop_front();
                want_last = exp_last.pop_front();
                check_value("o_out_data", 64'(o_out_data), want_data);
                check_value("o_out_bytes", 64'(o_out_bytes), 64'(want_bytes));
                check_value("o_out_last", 64'(o_out_last), 64'(want_last));
            end
        end
    end

    initial begin : driver
        int idx;
        int cnt;
        int beat;
        int waited;
        logic [7:0] hi;
        i_reset = 1'b1;
        i_in_data = '0;
        i_in_bytes = '0;
        i_in_last = 1'b0;
        i_in_valid = 1'b0;
        throttle_pct = 0;
        words_expected = 0;
        packets_sent = 0;
        data_rng = SEED;
        repeat (NUM_RESET) begin
            @(posedge i_clock);
            #1;
            check_value("o_in_ready in reset", 64'(o_in_ready), 64'd0);
            check_value("o_out_valid in reset", 64'(o_out_valid), 64'd0);
            check_value("o_word_count in reset", 64'(o_word_count), 64'd0);
            check_value("o_packet_count in reset", 64'(o_packet_count), 64'd0);
        end
        i_reset = 1'b0;
        waited = 0;
        while (!o_in_ready) begin
            waited = waited + 1;
            if (waited > TIMEOUT) begin
                $display("o_in_ready never rose after reset was released");
                stop_with_failure();
            end
            @(posedge i_clock);
            #1;
        end
        for (int c = 0; c < NUM_CASES; c++) begin
            pkt_bytes.delete();
            for (int i = 0; i < CASE_LEN[c]; i++) begin
                data_rng = next_rand(data_rng);
                pkt_bytes.push_back(data_rng[7:0]);
            end
            add_expected(CASE_LEN[c]);
            throttle_pct = CASE_THROTTLE[c];
            packets_sent = packets_sent + 1;
            idx = 0;
            beat = 0;
            while (idx < CASE_LEN[c]) begin
                cnt = beat_size(CASE_SPLIT[c], beat, CASE_LEN[c] - idx);
                // Unused high lane gets noise
                data_rng = next_rand(data_rng);
                hi = (cnt == 2) ? pkt_bytes[idx+1] : data_rng[15:8];
                send_beat({hi, pkt_bytes[idx]}, cnt, (idx + cnt) == CASE_LEN[c]);
                idx = idx + cnt;
                beat = beat + 1;
            end
            wait_drain();
            #1;
        end
        @(negedge i_clock);
        check_value("o_word_count", 64'(o_word_count), 64'(words_expected));
        check_value("o_packet_count", 64'(o_packet_count), 64'(packets_sent));
        $display("RESULT: PASS");
        $finish;
    end

endmodule : concat_tb
